// File: src/plic_settings.svh
/*
 * Build-time sizing for the interrupt controller.
 * Included by the package and by every module that needs a width.
 */
`ifndef PLIC_SETTINGS_SVH
`define PLIC_SETTINGS_SVH

// number of level-triggered sources, ids run from 1 to this value
`define PLIC_N_SOURCE 8

// highest priority a source can be given, 0 never wins over a threshold
`define PLIC_MAX_PRIO 7

// derived widths, the id needs room for 0 as "no interrupt"
`define PLIC_PRIO_W ($clog2(`PLIC_MAX_PRIO + 1))
`define PLIC_ID_W ($clog2(`PLIC_N_SOURCE + 1))

// width of the register port data bus
`define PLIC_DATA_W 32

`endif

// File: src/plic_pkg.sv
/*
 * Types shared by the interrupt controller blocks and its testbench.
 * Refer to them by scoped name, e.g. plic_pkg::plic_irq_t.
 */
`include "plic_settings.svh"

package plic_pkg;

  // one bit per interrupt source, bit i belongs to id i+1
  typedef logic [`PLIC_N_SOURCE-1:0] src_vec_t;

  // register map of the strobe port, addresses 12 to 15 are unmapped
  typedef enum logic [3:0] {
    REG_PRIO0     = 4'd0,
    REG_PRIO1     = 4'd1,
    REG_PRIO2     = 4'd2,
    REG_PRIO3     = 4'd3,
    REG_PRIO4     = 4'd4,
    REG_PRIO5     = 4'd5,
    REG_PRIO6     = 4'd6,
    REG_PRIO7     = 4'd7,
    REG_ENABLE    = 4'd8,
    REG_THRESHOLD = 4'd9,
    REG_CLAIM     = 4'd10,
    REG_PENDING   = 4'd11
  } reg_addr_e;

  // single-cycle register access, both strobes low means idle
  typedef struct packed {
    logic                    we;
    logic                    re;
    reg_addr_e               addr;
    logic [`PLIC_DATA_W-1:0] wdata;
  } reg_req_t;

  // configuration handed from the register block to the arbiter
  typedef struct packed {
    logic [`PLIC_N_SOURCE-1:0][`PLIC_PRIO_W-1:0] prio;
    src_vec_t                                    enable;
    logic [`PLIC_PRIO_W-1:0]                     threshold;
  } plic_cfg_t;

  // registered arbitration result, id is valid even when irq stays low
  typedef struct packed {
    logic                  irq;
    logic [`PLIC_ID_W-1:0] id;
  } plic_irq_t;

endpackage

// File: src/plic_reg_decode.sv
/*
 * Register block of the interrupt controller. Holds priorities, enable and
 * threshold, turns claim reads and completion writes into one-hot pulses
 * and returns registered read data one cycle after the read strobe.
 */
`timescale 1ns/100ps
`include "plic_settings.svh"

module plic_reg_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  plic_pkg::reg_req_t      reg_req_i,
  input  plic_pkg::src_vec_t      pending_i,
  input  plic_pkg::plic_irq_t     irq_i,
  output plic_pkg::plic_cfg_t     cfg_o,
  output plic_pkg::src_vec_t      claim_o,
  output plic_pkg::src_vec_t      complete_o,
  output logic [`PLIC_DATA_W-1:0] rdata_o
);

  localparam int IdW   = `PLIC_ID_W;
  localparam int DataW = `PLIC_DATA_W;

  plic_pkg::plic_cfg_t cfg_q;
  logic [DataW-1:0]    rdata_d;
  logic [DataW-1:0]    rdata_q;

  // configuration writes land on the next edge, claim and pending are not stored here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (reg_req_i.we) begin
      if (reg_req_i.addr == plic_pkg::REG_ENABLE) begin
        cfg_q.enable <= reg_req_i.wdata[`PLIC_N_SOURCE-1:0];
      end
      if (reg_req_i.addr == plic_pkg::REG_THRESHOLD) begin
        cfg_q.threshold <= reg_req_i.wdata[`PLIC_PRIO_W-1:0];
      end
      // priority registers sit at addresses 0 to N-1
      for (int i = 0; i < `PLIC_N_SOURCE; i++) begin
        if (reg_req_i.addr == plic_pkg::reg_addr_e'(i)) begin
          cfg_q.prio[i] <= reg_req_i.wdata[`PLIC_PRIO_W-1:0];
        end
      end
    end
  end

  // a claim read picks the source the arbiter currently reports,
  // a write to the claim register completes the id in the write data
  always_comb begin
    claim_o    = '0;
    complete_o = '0;
    for (int i = 0; i < `PLIC_N_SOURCE; i++) begin
      if (reg_req_i.re && reg_req_i.addr == plic_pkg::REG_CLAIM &&
          irq_i.id == IdW'(i + 1)) begin
        claim_o[i] = 1'b1;
      end
      // ids of 0 or beyond the source count never match
      if (reg_req_i.we && reg_req_i.addr == plic_pkg::REG_CLAIM &&
          reg_req_i.wdata == DataW'(i + 1)) begin
        complete_o[i] = 1'b1;
      end
    end
  end

  // read mux, narrower registers are zero extended and unmapped addresses read 0
  always_comb begin
    rdata_d = '0;
    case (reg_req_i.addr)
      plic_pkg::REG_ENABLE:    rdata_d[`PLIC_N_SOURCE-1:0] = cfg_q.enable;
      plic_pkg::REG_THRESHOLD: rdata_d[`PLIC_PRIO_W-1:0] = cfg_q.threshold;
      plic_pkg::REG_CLAIM:     rdata_d[IdW-1:0] = irq_i.id;
      plic_pkg::REG_PENDING:   rdata_d[`PLIC_N_SOURCE-1:0] = pending_i;
      default: begin
        for (int i = 0; i < `PLIC_N_SOURCE; i++) begin
          if (reg_req_i.addr == plic_pkg::reg_addr_e'(i)) begin
            rdata_d[`PLIC_PRIO_W-1:0] = cfg_q.prio[i];
          end
        end
      end
    endcase
  end

  // read data only moves on a read strobe and holds in between
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (reg_req_i.re) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_o   = cfg_q;
  assign rdata_o = rdata_q;

endmodule

// File: src/plic_gateway.sv
/*
 * Gateways for level-triggered sources. Each source owns a pending bit and
 * an in-service bit so that it requests once per claim and completion pair.
 */
`timescale 1ns/100ps

module plic_gateway (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  plic_pkg::src_vec_t src_i,
  input  plic_pkg::src_vec_t claim_i,
  input  plic_pkg::src_vec_t complete_i,
  output plic_pkg::src_vec_t pending_o
);

  plic_pkg::src_vec_t pending_d;
  plic_pkg::src_vec_t pending_q;
  plic_pkg::src_vec_t in_service_d;
  plic_pkg::src_vec_t in_service_q;

  // a high level is latched into pending unless the source is being served,
  // so a level that drops before the claim still leaves its request behind
  // the claim wins over a level that is still high in the same cycle
  assign pending_d = (pending_q | (src_i & ~in_service_q)) & ~claim_i;

  // the claim moves the request into service until the target completes it
  // a completion for a source that was never claimed just keeps it idle
  assign in_service_d = (in_service_q | claim_i) & ~complete_i;

  // once in service has cleared, a source still held high requests again
  // one edge later, since pending looks at the registered in-service bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      pending_q    <= pending_d;
      in_service_q <= in_service_d;
    end
  end

  // pending goes to the arbiter and reads back through the pending register
  assign pending_o = pending_q;

endmodule

// File: src/plic_target.sv
/*
 * Arbiter for the single target. A binary tree picks the enabled pending
 * source with the highest priority, lower id on a tie, and the result is
 * compared against the threshold and registered.
 */
`timescale 1ns/100ps
`include "plic_settings.svh"

module plic_target (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  plic_pkg::src_vec_t  pending_i,
  input  plic_pkg::plic_cfg_t cfg_i,
  output plic_pkg::plic_irq_t irq_o
);

  localparam int IdW       = `PLIC_ID_W;
  localparam int PrioW     = `PLIC_PRIO_W;
  // the leaf count is rounded up to a power of two
  localparam int NumLevels = $clog2(`PLIC_N_SOURCE);
  localparam int NumNodes  = 2 ** (NumLevels + 1) - 1;

  // node 0 is the root, the leaves take the last 2**NumLevels entries
  logic             is_tree  [NumNodes];
  logic [IdW-1:0]   id_tree  [NumNodes];
  logic [PrioW-1:0] max_tree [NumNodes];

  plic_pkg::plic_irq_t irq_d;
  plic_pkg::plic_irq_t irq_q;

  for (genvar level = 0; level <= NumLevels; level++) begin : gen_level
    // first node of this level and first node of the level below it
    localparam int Base0 = 2 ** level - 1;
    localparam int Base1 = 2 ** (level + 1) - 1;

    for (genvar offset = 0; offset < 2 ** level; offset++) begin : gen_node
      localparam int Pa = Base0 + offset;
      localparam int C0 = Base1 + 2 * offset;
      localparam int C1 = Base1 + 2 * offset + 1;

      if (level == NumLevels) begin : gen_leaf
        if (offset < `PLIC_N_SOURCE) begin : gen_src
          // a leaf is active only when its source is pending and enabled
          assign is_tree[Pa]  = pending_i[offset] & cfg_i.enable[offset];
          assign id_tree[Pa]  = IdW'(offset + 1);
          assign max_tree[Pa] = cfg_i.prio[offset];
        end else begin : gen_pad
          assign is_tree[Pa]  = 1'b0;
          assign id_tree[Pa]  = '0;
          assign max_tree[Pa] = '0;
        end
      end else begin : gen_inner
        logic sel_c1;

        // the upper child only wins when it is alone or strictly higher,
        // which hands ties to the lower id on the left
        assign sel_c1 = is_tree[C1] & (~is_tree[C0] | (max_tree[C1] > max_tree[C0]));

        assign is_tree[Pa]  = is_tree[C0] | is_tree[C1];
        assign id_tree[Pa]  = sel_c1 ? id_tree[C1] : id_tree[C0];
        assign max_tree[Pa] = sel_c1 ? max_tree[C1] : max_tree[C0];
      end
    end
  end

  // the winner's id is reported even when its priority fails the threshold
  assign irq_d.irq = is_tree[0] & (max_tree[0] > cfg_i.threshold);
  assign irq_d.id  = is_tree[0] ? id_tree[0] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o = irq_q;

endmodule

// File: src/plic_top.sv
/*
 * Top level of the single-target interrupt controller. Wires the register
 * block, the gateways and the arbiter to the register port and sources.
 */
`timescale 1ns/100ps
`include "plic_settings.svh"

module plic_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  plic_pkg::src_vec_t      src_i,
  input  plic_pkg::reg_req_t      reg_req_i,
  output logic [`PLIC_DATA_W-1:0] reg_rdata_o,
  output plic_pkg::plic_irq_t     irq_o
);

  // configuration from the register block to the arbiter
  plic_pkg::plic_cfg_t cfg;

  // one-hot pulses from the claim register to the gateways
  plic_pkg::src_vec_t claim;
  plic_pkg::src_vec_t complete;

  // latched requests, read by the arbiter and the pending register
  plic_pkg::src_vec_t pending;

  plic_reg_decode i_plic_reg_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .reg_req_i  (reg_req_i),
    .pending_i  (pending),
    .irq_i      (irq_o),
    .cfg_o      (cfg),
    .claim_o    (claim),
    .complete_o (complete),
    .rdata_o    (reg_rdata_o)
  );

  plic_gateway i_plic_gateway (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .src_i      (src_i),
    .claim_i    (claim),
    .complete_i (complete),
    .pending_o  (pending)
  );

  // the registered result feeds both the output and claim reads
  plic_target i_plic_target (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .pending_i (pending),
    .cfg_i     (cfg),
    .irq_o     (irq_o)
  );

endmodule

// File: test/plic_asserts.sv
/*
 * Concurrent checks on the interrupt controller internals.
 * Bound into plic_top, so every instance carries them.
 */
`timescale 1ns/100ps

module plic_asserts (
  input logic                clk_i,
  input logic                rst_ni,
  input plic_pkg::src_vec_t  claim_i,
  input plic_pkg::src_vec_t  complete_i,
  input plic_pkg::src_vec_t  pending_i,
  input plic_pkg::plic_cfg_t cfg_i,
  input plic_pkg::plic_irq_t irq_i
);

  // a single access addresses at most one source
  a_claim_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(claim_i))
    else $error("claim pulse is not one-hot");

  a_complete_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(complete_i))
    else $error("complete pulse is not one-hot");

  // the registered id follows the active set one edge later
  a_idle_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pending_i & cfg_i.enable) == '0 |=> irq_i.id == '0)
    else $error("irq id is nonzero with no enabled pending source");

  a_irq_has_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(irq_i.irq && irq_i.id == '0))
    else $error("irq is raised with id 0");

  // a claimed request leaves pending on the very next edge
  a_claim_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    claim_i != '0 |=> (pending_i & $past(claim_i)) == '0)
    else $error("claimed source is still pending");

endmodule

bind plic_top plic_asserts i_plic_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .claim_i    (claim),
  .complete_i (complete),
  .pending_i  (pending),
  .cfg_i      (cfg),
  .irq_i      (irq_o)
);

// File: test/plic_tb.sv
/*
 * Testbench for the single-target interrupt controller. Drives the register
 * port and the sources on the falling edge and checks irq_o and read data
 * against a cycle model of the gateways and the arbitration rule.
 */
`timescale 1ns/100ps
`include "plic_settings.svh"

module plic_tb;

  localparam int NSrc    = `PLIC_N_SOURCE;
  localparam int MaxPrio = `PLIC_MAX_PRIO;
  localparam int PrioW   = `PLIC_PRIO_W;
  localparam int IdW     = `PLIC_ID_W;
  localparam int DataW   = `PLIC_DATA_W;
  localparam int WaitMax = 40;

  logic                clk_i;
  logic                rst_ni;
  plic_pkg::src_vec_t  src_i;
  plic_pkg::reg_req_t  reg_req_i;
  logic [DataW-1:0]    reg_rdata_o;
  plic_pkg::plic_irq_t irq_o;

  // model state, stepped at every rising edge from the inputs seen there
  plic_pkg::plic_cfg_t m_cfg        = '0;
  plic_pkg::src_vec_t  m_pending    = '0;
  plic_pkg::src_vec_t  m_in_service = '0;
  plic_pkg::plic_irq_t exp_irq      = '0;
  logic [DataW-1:0]    exp_rdata    = '0;

  plic_top i_plic_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .src_i       (src_i),
    .reg_req_i   (reg_req_i),
    .reg_rdata_o (reg_rdata_o),
    .irq_o       (irq_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_irq(input string name, input plic_pkg::plic_irq_t exp,
                           input plic_pkg::plic_irq_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at time %0t: %s expected irq=%0b id=%0d, got irq=%0b id=%0d",
                          $time, name, exp.irq, exp.id, act.irq, act.id));
    end
  endtask

  task automatic check_rdata(input string name, input logic [DataW-1:0] exp,
                             input logic [DataW-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at time %0t: %s expected 'h%0h, got 'h%0h",
                          $time, name, exp, act));
    end
  endtask

  // highest enabled pending priority wins, the ascending scan with a strict
  // compare hands a tie to the lowest id
  function automatic plic_pkg::plic_irq_t expected_irq(input plic_pkg::src_vec_t pending,
                                                       input plic_pkg::plic_cfg_t cfg);
    plic_pkg::plic_irq_t res;
    int best_prio;
    int best_id;
    best_prio = -1;
    best_id   = 0;
    for (int i = 0; i < NSrc; i++) begin
      if (pending[i] && cfg.enable[i] && int'(cfg.prio[i]) > best_prio) begin
        best_prio = int'(cfg.prio[i]);
        best_id   = i + 1;
      end
    end
    res.irq = (best_id != 0) && (best_prio > int'(cfg.threshold));
    res.id  = IdW'(best_id);
    return res;
  endfunction

  // what a read of the given address returns from the model state
  function automatic logic [DataW-1:0] read_value(input plic_pkg::reg_addr_e addr);
    logic [DataW-1:0] val;
    val = '0;
    case (addr)
      plic_pkg::REG_ENABLE:    val = DataW'(m_cfg.enable);
      plic_pkg::REG_THRESHOLD: val = DataW'(m_cfg.threshold);
      plic_pkg::REG_CLAIM:     val = DataW'(exp_irq.id);
      plic_pkg::REG_PENDING:   val = DataW'(m_pending);
      default: begin
        for (int i = 0; i < NSrc; i++) begin
          if (int'(addr) == i) begin
            val = DataW'(m_cfg.prio[i]);
          end
        end
      end
    endcase
    return val;
  endfunction

  // the model sees the same edge as the DUT, so the claim uses the id on irq_o
  always @(posedge clk_i) begin
    plic_pkg::src_vec_t  claim_v;
    plic_pkg::src_vec_t  complete_v;
    plic_pkg::plic_irq_t next_irq;
    if (!rst_ni) begin
      m_cfg        = '0;
      m_pending    = '0;
      m_in_service = '0;
      exp_irq      = '0;
      exp_rdata    = '0;
    end else begin
      claim_v    = '0;
      complete_v = '0;
      for (int i = 0; i < NSrc; i++) begin
        if (reg_req_i.re && reg_req_i.addr == plic_pkg::REG_CLAIM &&
            int'(exp_irq.id) == i + 1) begin
          claim_v[i] = 1'b1;
        end
        if (reg_req_i.we && reg_req_i.addr == plic_pkg::REG_CLAIM &&
            reg_req_i.wdata == DataW'(i + 1)) begin
          complete_v[i] = 1'b1;
        end
      end
      if (reg_req_i.re) begin
        exp_rdata = read_value(reg_req_i.addr);
      end
      next_irq = expected_irq(m_pending, m_cfg);
      // gateway rule, a claim beats a level that is still high
      for (int i = 0; i < NSrc; i++) begin
        if (claim_v[i]) begin
          m_pending[i]    = 1'b0;
          m_in_service[i] = 1'b1;
        end else if (src_i[i] && !m_in_service[i]) begin
          m_pending[i] = 1'b1;
        end
        if (complete_v[i]) begin
          m_in_service[i] = 1'b0;
        end
      end
      if (reg_req_i.we) begin
        case (reg_req_i.addr)
          plic_pkg::REG_ENABLE:    m_cfg.enable = reg_req_i.wdata[NSrc-1:0];
          plic_pkg::REG_THRESHOLD: m_cfg.threshold = reg_req_i.wdata[PrioW-1:0];
          default: begin
            for (int i = 0; i < NSrc; i++) begin
              if (int'(reg_req_i.addr) == i) begin
                m_cfg.prio[i] = reg_req_i.wdata[PrioW-1:0];
              end
            end
          end
        endcase
      end
      exp_irq = next_irq;
    end
  end

  // outputs settle after the rising edge, so compare half a cycle later
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_irq("irq_o", exp_irq, irq_o);
      check_rdata("reg_rdata_o", exp_rdata, reg_rdata_o);
    end
  end

  task automatic reg_write(input plic_pkg::reg_addr_e addr, input logic [DataW-1:0] data);
    @(negedge clk_i);
    reg_req_i.we    = 1'b1;
    reg_req_i.re    = 1'b0;
    reg_req_i.addr  = addr;
    reg_req_i.wdata = data;
    @(negedge clk_i);
    reg_req_i = '0;
  endtask

  // the data is taken one cycle after the strobe, where it already holds
  task automatic reg_read(input plic_pkg::reg_addr_e addr, output logic [DataW-1:0] data);
    @(negedge clk_i);
    reg_req_i.we    = 1'b0;
    reg_req_i.re    = 1'b1;
    reg_req_i.addr  = addr;
    reg_req_i.wdata = '0;
    @(negedge clk_i);
    reg_req_i = '0;
    data      = reg_rdata_o;
  endtask

  task automatic wait_irq(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (irq_o.irq !== level && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (irq_o.irq !== level) begin
      abort_run($sformatf("irq_o.irq did not reach %0b within %0d cycles", level, max_cycles));
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni    = 1'b0;
    src_i     = '0;
    reg_req_i = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  initial begin
    logic [DataW-1:0]    rd;
    plic_pkg::plic_irq_t want;
    int                  op;
    int                  p;
    void'($urandom(68205));
    rst_ni    = 1'b0;
    src_i     = '0;
    reg_req_i = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    // everything reads zero after reset, the unmapped addresses too
    check_irq("irq_o", '0, irq_o);
    for (int a = 0; a < 16; a++) begin
      reg_read(plic_pkg::reg_addr_e'(a), rd);
      check_rdata("reg_rdata_o", '0, rd);
    end

    // register readback, with the model holding the last written values
    reg_write(plic_pkg::REG_PRIO3, DataW'(5));
    reg_read(plic_pkg::REG_PRIO3, rd);
    check_rdata("prio3", DataW'(5), rd);
    for (int i = 0; i < NSrc; i++) begin
      reg_write(plic_pkg::reg_addr_e'(i), DataW'($urandom_range(0, MaxPrio)));
    end
    reg_write(plic_pkg::REG_ENABLE, DataW'($urandom_range(0, 255)));
    reg_write(plic_pkg::REG_THRESHOLD, DataW'($urandom_range(0, MaxPrio)));
    @(negedge clk_i);
    src_i = plic_pkg::src_vec_t'($urandom_range(0, 255));
    repeat (3) @(negedge clk_i);
    for (int a = 0; a < 16; a++) begin
      reg_read(plic_pkg::reg_addr_e'(a), rd);
    end

    // random arbitration with claims, completions and forced ties
    for (int n = 0; n < 400; n++) begin
      op = $urandom_range(0, 8);
      case (op)
        0, 1: reg_write(plic_pkg::reg_addr_e'($urandom_range(0, NSrc - 1)),
                        DataW'($urandom_range(0, MaxPrio)));
        2: reg_write(plic_pkg::REG_ENABLE, DataW'($urandom_range(0, 255)));
        3: reg_write(plic_pkg::REG_THRESHOLD, DataW'($urandom_range(0, MaxPrio)));
        4: begin
          @(negedge clk_i);
          src_i = plic_pkg::src_vec_t'($urandom_range(0, 255));
        end
        5: reg_read(plic_pkg::REG_CLAIM, rd);
        6: reg_write(plic_pkg::REG_CLAIM, DataW'($urandom_range(0, NSrc + 1)));
        7: begin
          // one priority for all sources, so only the id decides
          p = $urandom_range(0, MaxPrio);
          for (int i = 0; i < NSrc; i++) begin
            reg_write(plic_pkg::reg_addr_e'(i), DataW'(p));
          end
        end
        default: reg_read(plic_pkg::REG_PENDING, rd);
      endcase
    end

    // ids 3 and 6 pending, the best priority sits right at the threshold
    apply_reset();
    reg_write(plic_pkg::REG_PRIO2, DataW'(4));
    reg_write(plic_pkg::REG_PRIO5, DataW'(2));
    reg_write(plic_pkg::REG_ENABLE, DataW'(8'h24));
    reg_write(plic_pkg::REG_THRESHOLD, DataW'(4));
    @(negedge clk_i);
    src_i = 8'h24;
    repeat (4) @(negedge clk_i);
    want.irq = 1'b0;
    want.id  = IdW'(3);
    check_irq("irq_o", want, irq_o);
    reg_write(plic_pkg::REG_THRESHOLD, DataW'(3));
    wait_irq(1'b1, WaitMax);
    want.irq = 1'b1;
    check_irq("irq_o", want, irq_o);

    // claim id 3, then id 6 is left below the threshold
    reg_read(plic_pkg::REG_CLAIM, rd);
    check_rdata("claim id", DataW'(3), rd);
    wait_irq(1'b0, WaitMax);
    want.irq = 1'b0;
    want.id  = IdW'(6);
    check_irq("irq_o", want, irq_o);
    // source 3 stays high while in service and must not come back
    repeat (6) @(negedge clk_i);
    check_irq("irq_o", want, irq_o);
    reg_read(plic_pkg::REG_PENDING, rd);
    check_rdata("pending", DataW'(8'h20), rd);
    reg_write(plic_pkg::REG_CLAIM, DataW'(3));
    wait_irq(1'b1, WaitMax);
    want.irq = 1'b1;
    want.id  = IdW'(3);
    check_irq("irq_o", want, irq_o);

    $display("Verification passed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
src/plic_pkg.sv
src/plic_reg_decode.sv
src/plic_gateway.sv
src/plic_target.sv
src/plic_top.sv
test/plic_asserts.sv
test/plic_tb.sv

// File: Makefile
# Verilator build and run for the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= plic_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
INCDIRS := $(patsubst +incdir+%,%,$(shell grep '^+incdir+' $(FILELIST)))
HDRS    := $(foreach d,$(INCDIRS),$(wildcard $(d)/*.svh))
BIN     := $(BUILD_DIR)/V$(TOP)

PASS_MSG := Verification passed

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
